//--- sim.f
swarm_task_pkg.sv
tsb_reg_pkg.sv
tile_mapper.sv
tsb.sv
lvt_tracker.sv
tsb_top.sv
tsb_properties.sv
tsb_tb.sv

//--- Bender.yml
package:
  name: tsb

sources:
  - swarm_task_pkg.sv
  - tsb_reg_pkg.sv
  - tile_mapper.sv
  - tsb.sv
  - lvt_tracker.sv
  - tsb_top.sv
  - target: simulation
    files:
      - tsb_properties.sv
      - tsb_tb.sv

//--- tsb_tb.sv
`timescale 1ns/1ns

module tsb_tb;

   import swarm_task_pkg::*;
   import tsb_reg_pkg::*;

   localparam int LOG_TSB_SIZE = 3;
   localparam int N_TILES = 4;
   localparam int N_ENTRIES = 2**LOG_TSB_SIZE;
   localparam int SCAN_WAIT = 2 * N_ENTRIES + 2;
   // roughly 110 transfers across all tests
   localparam int PLANNED_XFERS = 120;
   localparam int WATCHDOG_CYCLES = PLANNED_XFERS * 40 + 2000;

   typedef struct packed {
      logic                    retry;
      logic [LOG_TSB_SIZE-1:0] id;
      task_t                   data;
      logic                    tied;
      tile_id_t                dest;
      cq_slice_slot_t          cq;
      child_id_t               child;
   } enq_exp_t;

   typedef struct packed {
      logic                    ack;
      logic [LOG_TSB_SIZE-1:0] slot;
      epoch_t                  epoch;
      tq_slot_t                tq;
      tile_id_t                tile;
      cq_slice_slot_t          cq;
      child_id_t               child;
   } resp_exp_t;

   logic clk = 1'b0;
   logic rstn;
   logic s_wvalid, s_wready, s_tied;
   task_t s_wdata;
   cq_slice_slot_t s_cq_slot, m_cq_slot;
   child_id_t s_child_id, m_child_id;
   logic retry_valid, retry_ready, retry_abort, retry_tied;
   logic [LOG_TSB_SIZE-1:0] retry_tsb_id, task_enq_tsb_id, task_resp_tsb_id, m_tsb_slot;
   logic task_enq_valid, task_enq_ready, task_enq_tied;
   task_t task_enq_data;
   tile_id_t task_enq_dest_tile, m_tile_id;
   logic task_resp_valid, task_resp_ready, task_resp_ack;
   epoch_t task_resp_epoch, m_epoch;
   tq_slot_t task_resp_tq_slot, m_tq_slot;
   logic m_resp_valid, m_resp_ready, m_resp_ack;
   logic reg_wvalid, reg_arvalid, reg_rvalid;
   reg_addr_t reg_waddr, reg_araddr;
   reg_data_t reg_wdata, reg_rdata;
   logic almost_full, empty;
   ts_t lvt;

   // model of the buffer and of the mapper config
   enq_exp_t exp_enq[$];
   resp_exp_t exp_resp[$];
   enq_exp_t entries[N_ENTRIES];
   logic [N_ENTRIES-1:0] held = '0;
   reg_data_t cfg_tiles = N_TILES;
   logic cfg_hash = 1'b0;
   string test_name = "reset";

   tsb_top #(.LOG_TSB_SIZE(LOG_TSB_SIZE), .N_TILES(N_TILES)) dut (.*);

   always #10 clk = ~clk;

   task automatic report_failure(string msg);
      $display("%s: %s", test_name, msg);
      $display("Test failures found");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_eq(string what, logic [127:0] exp, logic [127:0] act);
      assert (act === exp) else begin
         $display("** Error [%s] %s: expected %0h, actual %0h", test_name, what, exp, act);
         $display("Test failures found");
         $fatal(1, "stopped at first error");
      end
   endtask

   function automatic task_t rand_task(task_type_t tt);
      task_t t;
      t.ttype = tt;
      // stay clear of the all ones marker
      t.ts = $urandom & 32'h7fff_ffff;
      t.payload.locale = $urandom;
      return t;
   endfunction

   function automatic tile_id_t ref_dest(task_t t, logic hash_on, reg_data_t tiles);
      logic [15:0] h;
      int n;
      n = (tiles == 0 || tiles > 16) ? 16 : int'(tiles);
      h = t.payload.locale[19:4];
      if (hash_on && t.ttype == TASK_TYPE_NORMAL) begin
         for (int i = 0; i < 16; i++) begin
            h[i] = ^(t.payload.locale[31:4] & HASH_KEYS[i][31:4]);
         end
      end
      if (t.ttype == TASK_TYPE_SPLITTER) begin
         return tile_id_t'(int'(t.payload.splitter.home_tile) % n);
      end
      return tile_id_t'(int'(h) % n);
   endfunction

   function automatic ts_t model_min();
      ts_t m;
      m = '1;
      for (int i = 0; i < N_ENTRIES; i++) begin
         if (held[i] && entries[i].data.ts < m) m = entries[i].data.ts;
      end
      return m;
   endfunction

   // monitor and compare on the rising edge
   always @(posedge clk) begin
      enq_exp_t e;
      resp_exp_t r;
      if (rstn) begin
         if (task_enq_valid && task_enq_ready) begin
            assert (exp_enq.size() != 0)
            else report_failure("a task left the buffer with none expected");
            e = exp_enq.pop_front();
            check_eq("enq data", e.data, task_enq_data);
            check_eq("enq tied", e.tied, task_enq_tied);
            check_eq("enq dest tile", e.dest, task_enq_dest_tile);
            if (e.retry) begin
               check_eq("enq tsb id", e.id, task_enq_tsb_id);
            end else begin
               assert (!held[task_enq_tsb_id]) else report_failure("new task reused a held entry");
               e.id = task_enq_tsb_id;
               entries[task_enq_tsb_id] = e;
               held[task_enq_tsb_id] = 1'b1;
            end
         end
         if (retry_valid && retry_ready) begin
            if (retry_abort) begin
               held[retry_tsb_id] = 1'b0;
            end else begin
               e = entries[retry_tsb_id];
               e.retry = 1'b1;
               e.tied = retry_tied;
               entries[retry_tsb_id].tied = retry_tied;
               exp_enq.push_back(e);
            end
         end
         if (s_wvalid && s_wready) begin
            e.retry = 1'b0;
            e.id = '0;
            e.data = s_wdata;
            e.tied = s_tied;
            e.dest = ref_dest(s_wdata, cfg_hash, cfg_tiles);
            e.cq = s_cq_slot;
            e.child = s_child_id;
            exp_enq.push_back(e);
         end
         if (task_resp_valid && task_resp_ready) begin
            e = entries[task_resp_tsb_id];
            if (e.tied) begin
               r = {task_resp_ack, task_resp_tsb_id, task_resp_epoch, task_resp_tq_slot,
                    e.dest, e.cq, e.child};
               exp_resp.push_back(r);
            end
            if (task_resp_ack) held[task_resp_tsb_id] = 1'b0;
         end
         if (m_resp_valid && m_resp_ready) begin
            assert (exp_resp.size() != 0)
            else report_failure("a response came back for an untied task");
            r = exp_resp.pop_front();
            check_eq("m_resp", r, {m_resp_ack, m_tsb_slot, m_epoch, m_tq_slot, m_tile_id,
                                   m_cq_slot, m_child_id});
         end
         if (reg_wvalid && reg_waddr == TSB_N_TILES) cfg_tiles = reg_wdata;
         if (reg_wvalid && reg_waddr == TSB_HASH_EN) cfg_hash = reg_wdata[0];
      end
   end

   task automatic send_task(task_t t, logic tied);
      @(negedge clk);
      s_wvalid = 1'b1;
      s_wdata = t;
      s_tied = tied;
      s_cq_slot = cq_slice_slot_t'($urandom);
      s_child_id = child_id_t'($urandom);
      do @(posedge clk); while (!s_wready);
      @(negedge clk);
      s_wvalid = 1'b0;
   endtask

   task automatic send_resp(int id, logic ack);
      @(negedge clk);
      task_resp_valid = 1'b1;
      task_resp_tsb_id = LOG_TSB_SIZE'(id);
      task_resp_ack = ack;
      task_resp_epoch = epoch_t'($urandom);
      task_resp_tq_slot = tq_slot_t'($urandom);
      do @(posedge clk); while (!task_resp_ready);
      @(negedge clk);
      task_resp_valid = 1'b0;
   endtask

   task automatic send_retry(int id, logic abort, logic tied);
      @(negedge clk);
      retry_valid = 1'b1;
      retry_tsb_id = LOG_TSB_SIZE'(id);
      retry_abort = abort;
      retry_tied = tied;
      do @(posedge clk); while (!retry_ready);
      @(negedge clk);
      retry_valid = 1'b0;
   endtask

   task automatic write_reg(reg_addr_t addr, reg_data_t data);
      @(negedge clk);
      reg_wvalid = 1'b1;
      reg_waddr = addr;
      reg_wdata = data;
      @(negedge clk);
      reg_wvalid = 1'b0;
   endtask

   task automatic read_reg(reg_addr_t addr, output reg_data_t data);
      @(negedge clk);
      reg_arvalid = 1'b1;
      reg_araddr = addr;
      @(negedge clk);
      reg_arvalid = 1'b0;
      check_eq("reg_rvalid", 1'b1, reg_rvalid);
      data = reg_rdata;
   endtask

   task automatic wait_drained();
      do @(negedge clk);
      while (exp_enq.size() != 0 || exp_resp.size() != 0 || task_enq_valid || m_resp_valid);
   endtask

   task automatic free_all();
      for (int i = 0; i < N_ENTRIES; i++) begin
         if (held[i]) send_resp(i, 1'b1);
      end
      wait_drained();
      check_eq("empty", 1'b1, empty);
   endtask

   initial begin
      int ids[$];
      reg_data_t rd;
      void'($urandom(8487));
      rstn = 1'b0;
      s_wvalid = 1'b0;
      s_wdata = '0;
      s_tied = 1'b0;
      s_cq_slot = '0;
      s_child_id = '0;
      retry_valid = 1'b0;
      retry_tsb_id = '0;
      retry_abort = 1'b0;
      retry_tied = 1'b0;
      task_enq_ready = 1'b1;
      task_resp_valid = 1'b0;
      task_resp_ack = 1'b0;
      task_resp_tsb_id = '0;
      task_resp_epoch = '0;
      task_resp_tq_slot = '0;
      m_resp_ready = 1'b1;
      reg_wvalid = 1'b0;
      reg_waddr = '0;
      reg_wdata = '0;
      reg_arvalid = 1'b0;
      reg_araddr = '0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
      check_eq("empty after reset", 1'b1, empty);
      check_eq("lvt after reset", 32'hffff_ffff, lvt);

      test_name = "unhashed mapping";
      for (int r = 0; r < 3; r++) begin
         for (int i = 0; i < 6; i++) send_task(rand_task(TASK_TYPE_NORMAL), $urandom_range(0, 1));
         wait_drained();
         free_all();
      end

      test_name = "hashed mapping";
      write_reg(TSB_N_TILES, 32'd3);
      write_reg(TSB_HASH_EN, 32'd1);
      for (int r = 0; r < 2; r++) begin
         for (int i = 0; i < 6; i++) send_task(rand_task(task_type_t'(i % 3)), 1'b1);
         wait_drained();
         free_all();
      end

      test_name = "responses";
      for (int i = 0; i < 4; i++) send_task(rand_task(TASK_TYPE_NORMAL), i[0]);
      wait_drained();
      // entries stay held without ack while the return path stalls
      fork
         begin
            for (int i = 0; i < N_ENTRIES; i++) begin
               if (held[i]) send_resp(i, 1'b0);
            end
         end
         begin
            for (int k = 0; k < 24; k++) begin
               @(negedge clk);
               m_resp_ready = (k % 3 == 2);
            end
            @(negedge clk);
            m_resp_ready = 1'b1;
         end
      join
      wait_drained();
      free_all();

      test_name = "retry and abort";
      for (int i = 0; i < 3; i++) send_task(rand_task(TASK_TYPE_NORMAL), 1'b0);
      wait_drained();
      for (int i = 0; i < N_ENTRIES; i++) begin
         if (held[i]) ids.push_back(i);
      end
      send_retry(ids[0], 1'b0, 1'b1);
      wait_drained();
      send_retry(ids[1], 1'b1, 1'b0);
      wait_drained();
      read_reg(TSB_ENTRY_VALID, rd);
      check_eq("entry valid after abort", reg_data_t'(held), rd);
      free_all();

      test_name = "back-pressure";
      fork
         begin
            for (int i = 0; i < 5; i++) send_task(rand_task(TASK_TYPE_NORMAL), 1'b1);
         end
         begin
            for (int k = 0; k < 24; k++) begin
               @(negedge clk);
               task_enq_ready = (k % 4 == 3);
            end
            @(negedge clk);
            task_enq_ready = 1'b1;
         end
      join
      wait_drained();
      check_eq("almost_full", $countones(held) > N_ENTRIES - 4, almost_full);
      for (int i = 0; i < 3; i++) send_task(rand_task(TASK_TYPE_NORMAL), 1'b1);
      wait_drained();
      send_task(rand_task(TASK_TYPE_NORMAL), 1'b1);
      check_eq("almost_full when full", 1'b1, almost_full);
      // mapper now holds one more and another waits behind it
      @(negedge clk);
      s_wvalid = 1'b1;
      s_wdata = rand_task(TASK_TYPE_NORMAL);
      repeat (20) begin
         @(posedge clk);
         check_eq("s_wready while full", 1'b0, s_wready);
      end
      send_resp(0, 1'b1);
      do @(posedge clk); while (!s_wready);
      @(negedge clk);
      s_wvalid = 1'b0;
      send_resp(1, 1'b1);
      wait_drained();
      free_all();

      test_name = "lvt tracking";
      for (int i = 0; i < 5; i++) send_task(rand_task(TASK_TYPE_NORMAL), 1'b0);
      wait_drained();
      repeat (SCAN_WAIT) @(negedge clk);
      check_eq("lvt with tasks held", model_min(), lvt);
      free_all();
      repeat (SCAN_WAIT) @(negedge clk);
      check_eq("lvt when empty", 32'hffff_ffff, lvt);
      read_reg(TSB_ENTRY_VALID, rd);
      check_eq("entry valid when empty", '0, rd);

      if (dut.u_tsb.tsb_props.fail_count == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Test failures found");
      $fatal(1, "watchdog expired");
   end

endmodule

//--- tsb_properties.sv
`timescale 1ns/1ns

module tsb_properties #(
   parameter int LOG_TSB_SIZE = 3
) (
   input logic                           clk,
   input logic                           rstn,
   input logic                           task_enq_valid,
   input logic                           task_enq_ready,
   input swarm_task_pkg::task_t          task_enq_data,
   input logic                           task_enq_tied,
   input swarm_task_pkg::tile_id_t       task_enq_dest_tile,
   input logic [LOG_TSB_SIZE-1:0]        task_enq_tsb_id,
   input logic                           m_resp_valid,
   input logic                           m_resp_ready,
   input logic                           m_resp_ack,
   input logic [LOG_TSB_SIZE-1:0]        m_tsb_slot,
   input swarm_task_pkg::epoch_t         m_epoch,
   input swarm_task_pkg::tq_slot_t       m_tq_slot,
   input swarm_task_pkg::tile_id_t       m_tile_id,
   input swarm_task_pkg::cq_slice_slot_t m_cq_slot,
   input swarm_task_pkg::child_id_t      m_child_id,
   input logic                           map_ready,
   input logic [LOG_TSB_SIZE:0]          occupancy,
   input logic                           empty
);

   int fail_count = 0;

   // stalled outputs hold their data
   assert property (@(posedge clk) disable iff (!rstn)
      task_enq_valid && !task_enq_ready |=> task_enq_valid &&
      $stable({task_enq_data, task_enq_tied, task_enq_dest_tile, task_enq_tsb_id}))
   else begin
      $error("task_enq changed while stalled");
      fail_count++;
   end

   assert property (@(posedge clk) disable iff (!rstn)
      m_resp_valid && !m_resp_ready |=> m_resp_valid &&
      $stable({m_resp_ack, m_tsb_slot, m_epoch, m_tq_slot,
               m_tile_id, m_cq_slot, m_child_id}))
   else begin
      $error("m_resp changed while stalled");
      fail_count++;
   end

   assert property (@(posedge clk) disable iff (!rstn) empty == (occupancy == '0))
   else begin
      $error("empty disagrees with occupancy");
      fail_count++;
   end

   assert property (@(posedge clk) disable iff (!rstn)
      int'(occupancy) == 2**LOG_TSB_SIZE |-> !map_ready)
   else begin
      $error("new task accepted with all entries valid");
      fail_count++;
   end

endmodule

bind tsb tsb_properties #(.LOG_TSB_SIZE(LOG_TSB_SIZE)) tsb_props (.*);

//--- tsb_top.sv
`timescale 1ns/1ns

module tsb_top #(
   parameter int LOG_TSB_SIZE = 3,
   parameter int N_TILES      = 4
) (
   input  logic                           clk,
   input  logic                           rstn,

   input  logic                           s_wvalid,
   output logic                           s_wready,
   input  swarm_task_pkg::task_t          s_wdata,
   input  logic                           s_tied,
   input  swarm_task_pkg::cq_slice_slot_t s_cq_slot,
   input  swarm_task_pkg::child_id_t      s_child_id,

   input  logic                           retry_valid,
   output logic                           retry_ready,
   input  logic [LOG_TSB_SIZE-1:0]        retry_tsb_id,
   input  logic                           retry_abort,
   input  logic                           retry_tied,

   output logic                           task_enq_valid,
   input  logic                           task_enq_ready,
   output swarm_task_pkg::task_t          task_enq_data,
   output logic                           task_enq_tied,
   output swarm_task_pkg::tile_id_t       task_enq_dest_tile,
   output logic [LOG_TSB_SIZE-1:0]        task_enq_tsb_id,

   input  logic                           task_resp_valid,
   output logic                           task_resp_ready,
   input  logic                           task_resp_ack,
   input  logic [LOG_TSB_SIZE-1:0]        task_resp_tsb_id,
   input  swarm_task_pkg::epoch_t         task_resp_epoch,
   input  swarm_task_pkg::tq_slot_t       task_resp_tq_slot,

   output logic                           m_resp_valid,
   input  logic                           m_resp_ready,
   output logic                           m_resp_ack,
   output logic [LOG_TSB_SIZE-1:0]        m_tsb_slot,
   output swarm_task_pkg::epoch_t         m_epoch,
   output swarm_task_pkg::tq_slot_t       m_tq_slot,
   output swarm_task_pkg::tile_id_t       m_tile_id,
   output swarm_task_pkg::cq_slice_slot_t m_cq_slot,
   output swarm_task_pkg::child_id_t      m_child_id,

   input  logic                           reg_wvalid,
   input  tsb_reg_pkg::reg_addr_t         reg_waddr,
   input  tsb_reg_pkg::reg_data_t         reg_wdata,
   input  logic                           reg_arvalid,
   input  tsb_reg_pkg::reg_addr_t         reg_araddr,
   output logic                           reg_rvalid,
   output tsb_reg_pkg::reg_data_t         reg_rdata,

   output logic                           almost_full,
   output swarm_task_pkg::ts_t            lvt,
   output logic                           empty
);

   import swarm_task_pkg::*;

   // mapper to buffer
   logic                    map_valid;
   logic                    map_ready;
   task_t                   map_task;
   logic                    map_tied;
   cq_slice_slot_t          map_cq_slot;
   child_id_t               map_child_id;
   tile_id_t                map_dest_tile;

   // tracker scan port
   logic [LOG_TSB_SIZE-1:0] scan_idx;
   logic                    scan_entry_valid;
   ts_t                     scan_ts;

   tile_mapper #(.N_TILES(N_TILES)) u_mapper (.*);

   tsb #(.LOG_TSB_SIZE(LOG_TSB_SIZE)) u_tsb (.*);

   lvt_tracker #(.LOG_TSB_SIZE(LOG_TSB_SIZE)) u_lvt (.*);

endmodule

//--- lvt_tracker.sv
`timescale 1ns/1ns

module lvt_tracker #(
   parameter int LOG_TSB_SIZE = 3
) (
   input  logic                    clk,
   input  logic                    rstn,
   input  logic                    scan_entry_valid,
   input  swarm_task_pkg::ts_t     scan_ts,
   output logic [LOG_TSB_SIZE-1:0] scan_idx,
   output swarm_task_pkg::ts_t     lvt
);

   import swarm_task_pkg::*;

   ts_t rolling_min;
   ts_t candidate;

   // empty slots count as no task
   assign candidate = scan_entry_valid ? scan_ts : '1;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         scan_idx    <= '0;
         rolling_min <= '1;
         lvt         <= '1;
      end else begin
         scan_idx <= scan_idx + 1'b1;
         if (scan_idx == '0) begin
            // publish last scan and restart with slot 0
            lvt         <= rolling_min;
            rolling_min <= candidate;
         end else if (candidate < rolling_min) begin
            rolling_min <= candidate;
         end
      end
   end

endmodule

//--- tsb.sv
`timescale 1ns/1ns

module tsb #(
   parameter int LOG_TSB_SIZE = 3
) (
   input  logic                           clk,
   input  logic                           rstn,

   input  logic                           map_valid,
   output logic                           map_ready,
   input  swarm_task_pkg::task_t          map_task,
   input  logic                           map_tied,
   input  swarm_task_pkg::cq_slice_slot_t map_cq_slot,
   input  swarm_task_pkg::child_id_t      map_child_id,
   input  swarm_task_pkg::tile_id_t       map_dest_tile,

   input  logic                           retry_valid,
   output logic                           retry_ready,
   input  logic [LOG_TSB_SIZE-1:0]        retry_tsb_id,
   input  logic                           retry_abort,
   input  logic                           retry_tied,

   output logic                           task_enq_valid,
   input  logic                           task_enq_ready,
   output swarm_task_pkg::task_t          task_enq_data,
   output logic                           task_enq_tied,
   output swarm_task_pkg::tile_id_t       task_enq_dest_tile,
   output logic [LOG_TSB_SIZE-1:0]        task_enq_tsb_id,

   input  logic                           task_resp_valid,
   output logic                           task_resp_ready,
   input  logic                           task_resp_ack,
   input  logic [LOG_TSB_SIZE-1:0]        task_resp_tsb_id,
   input  swarm_task_pkg::epoch_t         task_resp_epoch,
   input  swarm_task_pkg::tq_slot_t       task_resp_tq_slot,

   output logic                           m_resp_valid,
   input  logic                           m_resp_ready,
   output logic                           m_resp_ack,
   output logic [LOG_TSB_SIZE-1:0]        m_tsb_slot,
   output swarm_task_pkg::epoch_t         m_epoch,
   output swarm_task_pkg::tq_slot_t       m_tq_slot,
   output swarm_task_pkg::tile_id_t       m_tile_id,
   output swarm_task_pkg::cq_slice_slot_t m_cq_slot,
   output swarm_task_pkg::child_id_t      m_child_id,

   input  logic                           reg_arvalid,
   input  tsb_reg_pkg::reg_addr_t         reg_araddr,
   output logic                           reg_rvalid,
   output tsb_reg_pkg::reg_data_t         reg_rdata,

   input  logic [LOG_TSB_SIZE-1:0]        scan_idx,
   output logic                           scan_entry_valid,
   output swarm_task_pkg::ts_t            scan_ts,

   output logic                           almost_full,
   output logic                           empty
);

   import swarm_task_pkg::*;
   import tsb_reg_pkg::*;

   localparam int N_ENTRIES = 2**LOG_TSB_SIZE;

   logic [N_ENTRIES-1:0]    entry_valid;
   task_t                   entry_task     [N_ENTRIES];
   tile_id_t                entry_tile     [N_ENTRIES];
   cq_slice_slot_t          entry_cq_slot  [N_ENTRIES];
   child_id_t               entry_child_id [N_ENTRIES];
   logic                    entry_tied     [N_ENTRIES];

   logic [LOG_TSB_SIZE-1:0] free_idx;
   logic                    free_found;
   logic                    enq_open;
   logic                    map_fire;
   logic                    resend;
   logic                    abort;
   logic                    resp_fire;
   logic                    resp_free;
   logic [LOG_TSB_SIZE:0]   occupancy;

   // scan down so the lowest free entry wins
   always_comb begin
      free_found = 1'b0;
      free_idx   = '0;
      for (int i = N_ENTRIES - 1; i >= 0; i--) begin
         if (!entry_valid[i]) begin
            free_found = 1'b1;
            free_idx   = LOG_TSB_SIZE'(i);
         end
      end
   end

   assign enq_open    = !task_enq_valid || task_enq_ready;
   assign map_ready   = enq_open && free_found;
   // new tasks win over retries
   assign retry_ready = enq_open && !(map_valid && free_found);

   assign map_fire  = map_valid && map_ready;
   assign resend    = retry_valid && retry_ready && !retry_abort;
   assign abort     = retry_valid && retry_ready && retry_abort;
   assign resp_fire = task_resp_valid && task_resp_ready;
   assign resp_free = resp_fire && task_resp_ack;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         task_enq_valid <= 1'b0;
      end else if (map_fire || resend) begin
         task_enq_valid <= 1'b1;
      end else if (task_enq_ready) begin
         task_enq_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (map_fire) begin
         task_enq_data            <= map_task;
         task_enq_tied            <= map_tied;
         task_enq_dest_tile       <= map_dest_tile;
         task_enq_tsb_id          <= free_idx;
         entry_task[free_idx]     <= map_task;
         entry_tile[free_idx]     <= map_dest_tile;
         entry_cq_slot[free_idx]  <= map_cq_slot;
         entry_child_id[free_idx] <= map_child_id;
         entry_tied[free_idx]     <= map_tied;
      end else if (resend) begin
         task_enq_data            <= entry_task[retry_tsb_id];
         task_enq_tied            <= retry_tied;
         task_enq_dest_tile       <= entry_tile[retry_tsb_id];
         task_enq_tsb_id          <= retry_tsb_id;
         entry_tied[retry_tsb_id] <= retry_tied;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         entry_valid <= '0;
      end else begin
         if (map_fire) begin
            entry_valid[free_idx] <= 1'b1;
         end
         if (abort) begin
            entry_valid[retry_tsb_id] <= 1'b0;
         end
         if (resp_free) begin
            entry_valid[task_resp_tsb_id] <= 1'b0;
         end
      end
   end

   // responses only go back for tied tasks
   assign task_resp_ready = !m_resp_valid;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         m_resp_valid <= 1'b0;
      end else if (resp_fire && entry_tied[task_resp_tsb_id]) begin
         m_resp_valid <= 1'b1;
      end else if (m_resp_ready) begin
         m_resp_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (resp_fire && entry_tied[task_resp_tsb_id]) begin
         m_resp_ack <= task_resp_ack;
         m_tsb_slot <= task_resp_tsb_id;
         m_epoch    <= task_resp_epoch;
         m_tq_slot  <= task_resp_tq_slot;
         m_tile_id  <= entry_tile[task_resp_tsb_id];
         m_cq_slot  <= entry_cq_slot[task_resp_tsb_id];
         m_child_id <= entry_child_id[task_resp_tsb_id];
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         occupancy <= '0;
      end else begin
         occupancy <= occupancy + (LOG_TSB_SIZE+1)'(map_fire)
                      - (LOG_TSB_SIZE+1)'(resp_free) - (LOG_TSB_SIZE+1)'(abort);
      end
   end

   assign almost_full = int'(occupancy) > N_ENTRIES - 4;
   assign empty       = (entry_valid == '0);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         reg_rvalid <= 1'b0;
      end else begin
         reg_rvalid <= reg_arvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (reg_arvalid) begin
         if (reg_araddr == TSB_ENTRY_VALID) begin
            reg_rdata <= reg_data_t'(entry_valid);
         end else begin
            reg_rdata <= '0;
         end
      end
   end

   // read port for the lvt scan
   assign scan_entry_valid = entry_valid[scan_idx];
   assign scan_ts          = entry_task[scan_idx].ts;

endmodule

//--- tile_mapper.sv
`timescale 1ns/1ns

module tile_mapper #(
   parameter int N_TILES = 4
) (
   input  logic                           clk,
   input  logic                           rstn,

   input  logic                           s_wvalid,
   output logic                           s_wready,
   input  swarm_task_pkg::task_t          s_wdata,
   input  logic                           s_tied,
   input  swarm_task_pkg::cq_slice_slot_t s_cq_slot,
   input  swarm_task_pkg::child_id_t      s_child_id,

   input  logic                           reg_wvalid,
   input  tsb_reg_pkg::reg_addr_t         reg_waddr,
   input  tsb_reg_pkg::reg_data_t         reg_wdata,

   output logic                           map_valid,
   input  logic                           map_ready,
   output swarm_task_pkg::task_t          map_task,
   output logic                           map_tied,
   output swarm_task_pkg::cq_slice_slot_t map_cq_slot,
   output swarm_task_pkg::child_id_t      map_child_id,
   output swarm_task_pkg::tile_id_t       map_dest_tile
);

   import swarm_task_pkg::*;
   import tsb_reg_pkg::*;

   localparam logic [4:0] N_TILES_RST = (N_TILES < 1 || N_TILES > 16) ? 5'd16 : 5'(N_TILES);

   logic [4:0]  n_tiles;
   logic        hash_en;
   logic [15:0] hash_bits;
   logic [15:0] hashed;
   logic [15:0] dest_key;
   tile_id_t    dest_tile;
   logic        s_fire;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         n_tiles <= N_TILES_RST;
         hash_en <= 1'b0;
      end else if (reg_wvalid) begin
         case (reg_waddr)
            // out of range counts become 16 tiles
            TSB_N_TILES: begin
               if (reg_wdata == '0 || reg_wdata > 32'd16) begin
                  n_tiles <= 5'd16;
               end else begin
                  n_tiles <= reg_wdata[4:0];
               end
            end
            TSB_HASH_EN: hash_en <= reg_wdata[0];
            default: ;
         endcase
      end
   end

   always_comb begin
      for (int i = 0; i < 16; i++) begin
         hash_bits[i] = ^(s_wdata.payload.locale[31:4] & HASH_KEYS[i][31:4]);
      end
   end

   // only normal tasks are hashed
   assign hashed = (hash_en && s_wdata.ttype == TASK_TYPE_NORMAL) ?
                   hash_bits : s_wdata.payload.locale[19:4];

   assign dest_key = (s_wdata.ttype == TASK_TYPE_SPLITTER) ?
                     {12'd0, s_wdata.payload.splitter.home_tile} : hashed;

   assign dest_tile = tile_id_t'(dest_key % {11'd0, n_tiles});

   assign s_wready = !map_valid || map_ready;
   assign s_fire   = s_wvalid && s_wready;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         map_valid <= 1'b0;
      end else if (s_fire) begin
         map_valid <= 1'b1;
      end else if (map_ready) begin
         map_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (s_fire) begin
         map_task      <= s_wdata;
         map_tied      <= s_tied;
         map_cq_slot   <= s_cq_slot;
         map_child_id  <= s_child_id;
         map_dest_tile <= dest_tile;
      end
   end

endmodule

//--- tsb_reg_pkg.sv
package tsb_reg_pkg;

   localparam int REG_ADDR_W = 8;
   localparam int REG_DATA_W = 32;

   typedef logic [REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [REG_DATA_W-1:0] reg_data_t;

   // writable registers held in the mapper
   localparam reg_addr_t TSB_N_TILES = 8'h10;
   localparam reg_addr_t TSB_HASH_EN = 8'h14;

   // read-only vector served by the buffer
   localparam reg_addr_t TSB_ENTRY_VALID = 8'h20;

endpackage

//--- swarm_task_pkg.sv
package swarm_task_pkg;

   typedef enum logic [3:0] {
      TASK_TYPE_NORMAL    = 4'd0,
      TASK_TYPE_SPLITTER  = 4'd1,
      TASK_TYPE_TERMINATE = 4'd2
   } task_type_t;

   // all ones marks no task
   typedef logic [31:0] ts_t;

   typedef logic [31:0] locale_view_t;

   typedef struct packed {
      logic [3:0]  home_tile;
      logic [27:0] range_base;
   } splitter_view_t;

   // normal and terminate tasks read a locale, splitters a home tile and range
   typedef union packed {
      locale_view_t   locale;
      splitter_view_t splitter;
   } task_payload_u;

   typedef struct packed {
      task_type_t    ttype;
      ts_t           ts;
      task_payload_u payload;
   } task_t;

   typedef logic [3:0] tile_id_t;
   typedef logic [5:0] cq_slice_slot_t;
   typedef logic [2:0] child_id_t;
   typedef logic [7:0] epoch_t;
   typedef logic [6:0] tq_slot_t;

   // one key per bit of the hashed locale
   localparam logic [0:15][31:0] HASH_KEYS = {
      32'h7b1e90c4, 32'h4d02a6f3, 32'hc95f3817, 32'h18e4bd62,
      32'hae3071d9, 32'h5326cf80, 32'hf0a94e1b, 32'h2687d35e,
      32'h91bc0a47, 32'h6ef5218c, 32'h0d4b7ea3, 32'hb7c86215,
      32'h3f1d5cb8, 32'he2639f04, 32'h84a7e3d6, 32'h59f016ab
   };

endpackage
